/* logic/lspcBusPkg.sv */
`default_nettype none

package lspcBusPkg;

	// CPU side data word
	typedef logic [15:0] cpuWord;

	// Word index on the CPU bus, M68K address bits 3..1
	typedef logic [2:0] regAddr;

	// Bit 15 selects the zone, 14..0 is the offset
	typedef logic [15:0] vramAddr;

	// Register map
	localparam regAddr addrVramAddr  = 3'd0;    // Set address, triggers a read
	localparam regAddr addrVramData  = 3'd1;    // Write data, then advance
	localparam regAddr addrModulo    = 3'd2;
	localparam regAddr addrMode      = 3'd3;
	localparam regAddr addrTimerHigh = 3'd4;    // Reload bits 31..16
	localparam regAddr addrTimerLow  = 3'd5;    // Reload bits 15..0
	localparam regAddr addrIrqAck    = 3'd6;
	localparam regAddr addrTimerStop = 3'd7;

	// One register write as seen by the engines
	typedef struct packed {
		logic strobe;       // Single cycle
		regAddr addr;
		cpuWord data;
	} regWrite;

endpackage

`default_nettype wire

/* logic/lspcVideoPkg.sv */
`default_nettype none

package lspcVideoPkg;

	typedef logic [8:0] lineCount;      // Vertical count
	typedef logic [31:0] timerWord;
	typedef logic [2:0] aaCount;        // Auto-animation frame
	typedef logic [2:0] irqBits;

	// Bit positions in irqBits
	localparam int irqVBlank   = 0;
	localparam int irqTimer    = 1;
	localparam int irqColdBoot = 2;

	// Mode register, same order as data bits 15..3 of the write
	typedef struct packed {
		logic [7:0] aaSpeed;        // Frames per AA step, minus one
		logic [2:0] timerMode;      // Reload on low write / vblank / zero
		logic timerIrqEn;
		logic aaDisable;
	} lspcMode;

endpackage

`default_nettype wire

/* logic/lspcBusPort.sv */
`timescale 1ns/1ps
`default_nettype none

module lspcBusPort
	import lspcBusPkg::*;
	import lspcVideoPkg::*;
#(
	parameter bit palMode = 1'b0
)
(
	input wire clk24M,
	input wire nRESET,
	input wire regAddr cpuAddr,
	input wire cpuWord cpuDataIn,
	input wire nLspWe,
	input wire nLspOe,
	input wire cpuWord readBuffer,
	input wire cpuWord modulo,
	input wire lineCount vCount,
	input wire aaCount aa,
	output regWrite regWr,
	output lspcMode mode,
	output cpuWord cpuDataOut,
	output logic cpuDataOutEn
);

	logic [2:0] weSync;     // Two sync flops plus one of history
	logic [1:0] oeSync;
	logic weFall;
	logic strobe;
	regAddr wrAddr;
	cpuWord wrData;
	cpuWord modeReadback;

	// Falling edge of the write strobe, seen after the second flop
	assign weFall = ~weSync[1] & weSync[2];

	always_ff @(posedge clk24M)
	begin
		if (!nRESET)
		begin
			weSync <= 3'b111;       // Strobes idle high
			oeSync <= 2'b11;
			strobe <= 1'b0;
		end
		else
		begin
			weSync <= {weSync[1:0], nLspWe};
			oeSync <= {oeSync[0], nLspOe};
			strobe <= weFall;
		end
	end

	// CPU holds address and data stable while nLspWe is low
	always_ff @(posedge clk24M)
	begin
		if (weFall)
		begin
			wrAddr <= cpuAddr;
			wrData <= cpuDataIn;
		end
	end

	assign regWr = '{strobe: strobe, addr: wrAddr, data: wrData};

	// Mode register, bits 2..0 of the data are not stored
	always_ff @(posedge clk24M)
	begin
		if (!nRESET)
			mode <= '0;
		else if (strobe && wrAddr == addrMode)
			mode <= lspcMode'(wrData[15:3]);
	end

	// Line, three zeros, video mode, AA frame
	assign modeReadback = {vCount, 3'b000, palMode, aa};

	// Drive only on a read, never during a write
	assign cpuDataOutEn = ~oeSync[1] & weSync[1];

	always_comb
	begin
		case (cpuAddr)
			addrVramAddr, addrVramData, addrTimerHigh, addrTimerLow:
				cpuDataOut = readBuffer;
			addrModulo, addrIrqAck:
				cpuDataOut = modulo;
			default:
				cpuDataOut = modeReadback;      // Indexes 3 and 7
		endcase
	end

	// No back-pressure, engines need 4 cycles between writes
	writeSpacing: assert property (@(posedge clk24M) disable iff (!nRESET)
		strobe |-> !$past(strobe, 1) && !$past(strobe, 2) && !$past(strobe, 3))
		else $error("CPU writes closer than 4 cycles");

endmodule

`default_nettype wire

/* logic/lspcVramPort.sv */
`timescale 1ns/1ps
`default_nettype none

module lspcVramPort
	import lspcBusPkg::*;
(
	input wire clk24M,
	input wire nRESET,
	input wire regWrite regWr,
	input wire cpuWord vramRdData,
	output vramAddr vramAddrOut,
	output cpuWord vramWrData,
	output logic vramWe,
	output cpuWord readBuffer,
	output cpuWord modulo
);

	vramAddr addrReg;
	cpuWord modReg;
	cpuWord readBuf;
	cpuWord writeBuf;
	logic weReg;
	logic [1:0] readPipe;       // Address out, then data back
	logic [14:0] nextOffset;
	logic setAddr;
	logic writeData;
	logic setModulo;

	assign setAddr = regWr.strobe && regWr.addr == addrVramAddr;
	assign writeData = regWr.strobe && regWr.addr == addrVramData;
	assign setModulo = regWr.strobe && regWr.addr == addrModulo;

	// Offset wraps in 15 bits
	assign nextOffset = addrReg[14:0] + modReg[14:0];

	always_ff @(posedge clk24M)
	begin
		if (!nRESET)
		begin
			addrReg <= '0;
			modReg <= '0;
			readBuf <= '0;
			weReg <= 1'b0;
			readPipe <= '0;
		end
		else
		begin
			readPipe <= {readPipe[0], setAddr};
			weReg <= writeData;             // One cycle at the old address
			if (setAddr)
				addrReg <= regWr.data;
			else if (weReg)
				addrReg <= {addrReg[15], nextOffset};   // Zone bit kept
			if (setModulo)
				modReg <= regWr.data;
			if (readPipe[1])
				readBuf <= vramRdData;      // Memory answers one cycle after the address
		end
	end

	// Held until the next data write
	always_ff @(posedge clk24M)
	begin
		if (!nRESET)
			writeBuf <= '0;
		else if (writeData)
			writeBuf <= regWr.data;
	end

	assign vramAddrOut = addrReg;
	assign vramWrData = writeBuf;
	assign vramWe = weReg;
	assign readBuffer = readBuf;
	assign modulo = modReg;

	// Each data write makes a single write cycle
	singleWrite: assert property (@(posedge clk24M) disable iff (!nRESET)
		vramWe |-> !$past(vramWe))
		else $error("vramWe high for two cycles");

endmodule

`default_nettype wire

/* logic/lspcTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module lspcTimer
	import lspcBusPkg::*;
	import lspcVideoPkg::*;
(
	input wire clk24M,
	input wire nRESET,
	input wire regWrite regWr,
	input wire lspcMode mode,
	input wire vBlank,
	input wire vBlankLevel,
	output logic timerEvent
);

	timerWord reload;
	timerWord count;
	logic stopBit;          // Pause during blanking, for PAL
	logic paused;
	logic atZero;
	logic highWrite;
	logic lowWrite;

	assign highWrite = regWr.strobe && regWr.addr == addrTimerHigh;
	assign lowWrite = regWr.strobe && regWr.addr == addrTimerLow;
	assign paused = stopBit & vBlankLevel;
	assign atZero = (count == '0) && !paused;

	always_ff @(posedge clk24M)
	begin
		if (!nRESET)
		begin
			reload <= '0;
			stopBit <= 1'b0;
			count <= '0;
			timerEvent <= 1'b0;
		end
		else
		begin
			timerEvent <= atZero & mode.timerIrqEn;
			if (highWrite)
				reload[31:16] <= regWr.data;
			if (lowWrite)
				reload[15:0] <= regWr.data;
			if (regWr.strobe && regWr.addr == addrTimerStop)
				stopBit <= regWr.data[0];

			// Reload sources in priority order
			if (lowWrite && mode.timerMode[0])
				count <= {reload[31:16], regWr.data};   // New low half
			else if (vBlank && mode.timerMode[1])
				count <= reload;
			else if (atZero && mode.timerMode[2])
				count <= reload;
			else if (!paused)
				count <= count - 1'b1;      // Wraps without auto reload
		end
	end

endmodule

`default_nettype wire

/* logic/lspcRaster.sv */
`timescale 1ns/1ps
`default_nettype none

module lspcRaster
	import lspcVideoPkg::*;
#(
	parameter int lineLength = 384,
	parameter int frameLines = 264,
	parameter int vBlankLine = 248
)
(
	input wire clk24M,
	input wire nRESET,
	input wire lspcMode mode,
	output lineCount vCount,
	output aaCount aa,
	output logic vBlank,
	output logic vBlankLevel
);

	localparam int hBits = $clog2(lineLength);
	localparam logic [hBits-1:0] lastPixel = hBits'(lineLength - 1);
	localparam lineCount lastLine = lineCount'(frameLines - 1);
	localparam lineCount blankStart = lineCount'(vBlankLine);

	logic [hBits-1:0] hCount;
	lineCount nextLine;
	logic lineEnd;
	logic [7:0] frameCnt;       // Frames since last AA step

	assign lineEnd = hCount == lastPixel;
	assign nextLine = (vCount == lastLine) ? '0 : vCount + 1'b1;

	always_ff @(posedge clk24M)
	begin
		if (!nRESET)
		begin
			hCount <= '0;
			vCount <= '0;
			vBlank <= 1'b0;
			vBlankLevel <= 1'b0;
		end
		else
		begin
			vBlank <= 1'b0;
			if (lineEnd)
			begin
				hCount <= '0;
				vCount <= nextLine;
				vBlank <= nextLine == blankStart;       // First pixel of the blank line
				vBlankLevel <= nextLine >= blankStart;  // Drops at frame wrap
			end
			else
				hCount <= hCount + 1'b1;
		end
	end

	// One frame tick per vertical blank
	always_ff @(posedge clk24M)
	begin
		if (!nRESET)
		begin
			frameCnt <= '0;
			aa <= '0;
		end
		else if (vBlank)
		begin
			if (frameCnt == mode.aaSpeed)
			begin
				frameCnt <= '0;
				if (!mode.aaDisable)
					aa <= aa + 1'b1;
			end
			else
				frameCnt <= frameCnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* logic/lspcIrqCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module lspcIrqCtrl
	import lspcBusPkg::*;
	import lspcVideoPkg::*;
(
	input wire clk24M,
	input wire nRESET,
	input wire regWrite regWr,
	input wire vBlank,
	input wire timerEvent,
	output irqBits irqPending
);

	irqBits ackBits;
	irqBits setBits;

	// Ack data bit 1 clears that pending bit
	assign ackBits = (regWr.strobe && regWr.addr == addrIrqAck) ? regWr.data[2:0] : '0;

	always_comb
	begin
		setBits = '0;
		setBits[irqVBlank] = vBlank;
		setBits[irqTimer] = timerEvent;     // Cold boot only comes from reset
	end

	always_ff @(posedge clk24M)
	begin
		if (!nRESET)
			irqPending <= irqBits'(1 << irqColdBoot);
		else
			irqPending <= (irqPending & ~ackBits) | setBits;   // Set beats clear
	end

endmodule

`default_nettype wire

/* logic/lspcTop.sv */
`timescale 1ns/1ps
`default_nettype none

module lspcTop
	import lspcBusPkg::*;
	import lspcVideoPkg::*;
#(
	parameter int lineLength = 384,
	parameter int frameLines = 264,
	parameter int vBlankLine = 248,
	parameter bit palMode = 1'b0
)
(
	input wire clk24M,
	input wire nRESET,
	input wire regAddr cpuAddr,
	input wire cpuWord cpuDataIn,
	input wire nLspWe,
	input wire nLspOe,
	input wire cpuWord vramRdData,
	output cpuWord cpuDataOut,
	output logic cpuDataOutEn,
	output vramAddr vramAddrOut,
	output cpuWord vramWrData,
	output logic vramWe,
	output irqBits irqPending
);

	regWrite regWr;         // To every engine
	lspcMode mode;
	cpuWord readBuffer;
	cpuWord modulo;
	lineCount vCount;
	aaCount aa;
	logic vBlank;           // Single cycle
	logic vBlankLevel;
	logic timerEvent;

	lspcBusPort #(
		.palMode(palMode)
	) i_lspcBusPort (
		.clk24M(clk24M),
		.nRESET(nRESET),
		.cpuAddr(cpuAddr),
		.cpuDataIn(cpuDataIn),
		.nLspWe(nLspWe),
		.nLspOe(nLspOe),
		.readBuffer(readBuffer),
		.modulo(modulo),
		.vCount(vCount),
		.aa(aa),
		.regWr(regWr),
		.mode(mode),
		.cpuDataOut(cpuDataOut),
		.cpuDataOutEn(cpuDataOutEn)
	);

	lspcVramPort i_lspcVramPort (
		.clk24M(clk24M),
		.nRESET(nRESET),
		.regWr(regWr),
		.vramRdData(vramRdData),
		.vramAddrOut(vramAddrOut),
		.vramWrData(vramWrData),
		.vramWe(vramWe),
		.readBuffer(readBuffer),
		.modulo(modulo)
	);

	lspcTimer i_lspcTimer (
		.clk24M(clk24M),
		.nRESET(nRESET),
		.regWr(regWr),
		.mode(mode),
		.vBlank(vBlank),
		.vBlankLevel(vBlankLevel),
		.timerEvent(timerEvent)
	);

	lspcRaster #(
		.lineLength(lineLength),
		.frameLines(frameLines),
		.vBlankLine(vBlankLine)
	) i_lspcRaster (
		.clk24M(clk24M),
		.nRESET(nRESET),
		.mode(mode),
		.vCount(vCount),
		.aa(aa),
		.vBlank(vBlank),
		.vBlankLevel(vBlankLevel)
	);

	lspcIrqCtrl i_lspcIrqCtrl (
		.clk24M(clk24M),
		.nRESET(nRESET),
		.regWr(regWr),
		.vBlank(vBlank),
		.timerEvent(timerEvent),
		.irqPending(irqPending)
	);

endmodule

`default_nettype wire

/* tests/lspcTb.sv */
`timescale 1ns/1ps
`default_nettype none

module lspcTb
	import lspcBusPkg::*;
	import lspcVideoPkg::*;
();

	localparam int rowGap = 6;          // Idle cycles after each row
	localparam int maxRows = 64;

	// Operation kinds in the stimulus table
	typedef enum logic [2:0] {
		opWrite,        // Register write
		opRead,         // Read and compare under mask
		opWaitIrq,      // Wait for mask bits, data is the cycle limit
		opIrq,          // Compare pending bits under mask
		opMem,          // Compare memory word at data
		opAddr,         // Compare VRAM address output
		opSnapAa,       // Remember the AA frame
		opAaStep        // AA frame moved by data since the snapshot
	} rowOp;

	typedef struct packed {
		rowOp op;
		regAddr idx;
		cpuWord data;
		cpuWord expected;
		cpuWord mask;
	} stimRow;

	logic clk24M;
	logic nRESET;
	regAddr cpuAddr;
	cpuWord cpuDataIn;
	logic nLspWe;
	logic nLspOe;
	cpuWord vramRdData;
	cpuWord cpuDataOut;
	logic cpuDataOutEn;
	vramAddr vramAddrOut;
	cpuWord vramWrData;
	logic vramWe;
	irqBits irqPending;

	cpuWord vram [0:32767];     // External VRAM, zone bit ignored
	stimRow stimTable [0:maxRows-1];
	int rowCount;
	cpuWord lcgWords [0:5];
	aaCount aaSnap;

	lspcTop #(
		.lineLength(16),
		.frameLines(12),
		.vBlankLine(10),
		.palMode(1'b1)
	) i_lspcTop (
		.clk24M(clk24M),
		.nRESET(nRESET),
		.cpuAddr(cpuAddr),
		.cpuDataIn(cpuDataIn),
		.nLspWe(nLspWe),
		.nLspOe(nLspOe),
		.vramRdData(vramRdData),
		.cpuDataOut(cpuDataOut),
		.cpuDataOutEn(cpuDataOutEn),
		.vramAddrOut(vramAddrOut),
		.vramWrData(vramWrData),
		.vramWe(vramWe),
		.irqPending(irqPending)
	);

	initial
	begin
		clk24M = 1'b0;
		forever #4 clk24M = ~clk24M;    // 8 ns period
	end

	// Memory model, read data one cycle after the address
	initial
	begin
		for (int addr = 0; addr < 32768; addr++)
			vram[addr] = cpuWord'(addr) ^ 16'hA5C3;
		vramRdData = '0;
		forever
		begin
			@(posedge clk24M);
			if (vramWe)
				vram[vramAddrOut[14:0]] <= vramWrData;
			vramRdData <= vram[vramAddrOut[14:0]];
		end
	end

	function automatic logic [31:0] lcgStep(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic stopOnError(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic compareValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			stopOnError($sformatf("mismatch %s: got %h, expected %h", name, actual, expected));
	endtask

	task automatic addRow(input rowOp op, input regAddr idx, input cpuWord data,
		input cpuWord expected, input cpuWord mask);
		stimRow row;
		row.op = op;
		row.idx = idx;
		row.data = data;
		row.expected = expected;
		row.mask = mask;
		stimTable[rowCount] = row;
		rowCount++;
	endtask

	// Strobe low for four cycles, address and data held throughout
	task automatic writeReg(input regAddr idx, input cpuWord value);
		@(posedge clk24M);
		cpuAddr <= idx;
		cpuDataIn <= value;
		nLspWe <= 1'b0;
		repeat (4) @(posedge clk24M);
		nLspWe <= 1'b1;
	endtask

	task automatic readReg(input regAddr idx, output cpuWord value);
		@(posedge clk24M);
		cpuAddr <= idx;
		nLspOe <= 1'b0;
		repeat (4) @(posedge clk24M);
		@(negedge clk24M);          // Stable mid-cycle
		compareValue("cpuDataOutEn", 32'(cpuDataOutEn), 32'd1);
		value = cpuDataOut;
		@(posedge clk24M);
		nLspOe <= 1'b1;
	endtask

	task automatic waitIrq(input irqBits bits, input int limit);
		int cycles;
		cycles = 0;
		@(negedge clk24M);
		while (((irqPending & bits) == '0) && (cycles < limit))
		begin
			@(negedge clk24M);
			cycles++;
		end
		if ((irqPending & bits) == '0)
			stopOnError($sformatf("interrupt %b not raised within %0d cycles", bits, limit));
	endtask

	// Quiet outputs right after reset
	task automatic checkIdle();
		repeat (4)
		begin
			@(negedge clk24M);
			compareValue("vramWe", 32'(vramWe), 32'd0);
			compareValue("cpuDataOutEn", 32'(cpuDataOutEn), 32'd0);
		end
	endtask

	task automatic applyRow(input stimRow row);
		cpuWord word;
		case (row.op)
			opWrite:
				writeReg(row.idx, row.data);
			opRead:
			begin
				readReg(row.idx, word);
				compareValue($sformatf("cpuDataOut[%0d]", row.idx), 32'(word & row.mask),
					32'(row.expected));
			end
			opWaitIrq:
				waitIrq(irqBits'(row.mask[2:0]), int'(row.data));
			opIrq:
			begin
				@(negedge clk24M);
				compareValue("irqPending", 32'(irqPending & row.mask[2:0]), 32'(row.expected));
			end
			opMem:
			begin
				@(negedge clk24M);
				compareValue($sformatf("vram[%h]", row.data), 32'(vram[row.data[14:0]]),
					32'(row.expected));
			end
			opAddr:
			begin
				@(negedge clk24M);
				compareValue("vramAddrOut", 32'(vramAddrOut), 32'(row.expected));
			end
			opSnapAa:
			begin
				readReg(addrMode, word);
				aaSnap = word[2:0];
			end
			default:
			begin
				readReg(addrMode, word);
				compareValue("aa", 32'(word[2:0]), 32'(aaCount'(aaSnap + row.data[2:0])));
			end
		endcase
	endtask

	task automatic buildTable();
		logic [31:0] state;
		state = 32'd5;          // Seed
		for (int k = 0; k < 6; k++)
		begin
			state = lcgStep(state);
			lcgWords[k] = state[31:16];
		end
		rowCount = 0;
		addRow(opIrq, 3'd0, 16'h0000, 16'h0004, 16'h0007);      // Cold boot only
		// Modulo 3 burst from 0010
		addRow(opWrite, addrModulo, 16'h0003, 16'h0000, 16'h0000);
		addRow(opWrite, addrVramAddr, 16'h0010, 16'h0000, 16'h0000);
		for (int k = 0; k < 4; k++)
			addRow(opWrite, addrVramData, lcgWords[k], 16'h0000, 16'h0000);
		for (int k = 0; k < 4; k++)
			addRow(opMem, 3'd0, cpuWord'(16'h0010 + 3 * k), lcgWords[k], 16'h0000);
		addRow(opAddr, 3'd0, 16'h0000, 16'h001C, 16'h0000);
		addRow(opWrite, addrVramAddr, 16'h0013, 16'h0000, 16'h0000);
		addRow(opRead, addrVramAddr, 16'h0000, lcgWords[1], 16'hFFFF);
		// Offset wrap in zone 1
		addRow(opWrite, addrVramAddr, 16'hFFFF, 16'h0000, 16'h0000);
		addRow(opWrite, addrVramData, lcgWords[4], 16'h0000, 16'h0000);
		addRow(opMem, 3'd0, 16'h7FFF, lcgWords[4], 16'h0000);
		addRow(opAddr, 3'd0, 16'h0000, 16'h8002, 16'h0000);
		addRow(opWrite, addrVramData, lcgWords[5], 16'h0000, 16'h0000);
		addRow(opMem, 3'd0, 16'h0002, lcgWords[5], 16'h0000);
		addRow(opAddr, 3'd0, 16'h0000, 16'h8005, 16'h0000);
		addRow(opRead, addrModulo, 16'h0000, 16'h0003, 16'hFFFF);
		addRow(opRead, addrMode, 16'h0000, 16'h0008, 16'h0008);    // Video mode bit
		// Timer, IRQ enable and reload on low write, 40 cycles
		addRow(opWrite, addrMode, 16'h0030, 16'h0000, 16'h0000);
		addRow(opWrite, addrTimerHigh, 16'h0000, 16'h0000, 16'h0000);
		addRow(opWrite, addrTimerLow, 16'h0028, 16'h0000, 16'h0000);
		addRow(opWaitIrq, 3'd0, 16'd200, 16'h0000, 16'h0002);
		addRow(opWrite, addrIrqAck, 16'h0002, 16'h0000, 16'h0000);
		addRow(opIrq, 3'd0, 16'h0000, 16'h0000, 16'h0002);
		addRow(opWrite, addrIrqAck, 16'h0004, 16'h0000, 16'h0000);
		addRow(opIrq, 3'd0, 16'h0000, 16'h0000, 16'h0004);
		// AA step every frame
		addRow(opWrite, addrMode, 16'h0000, 16'h0000, 16'h0000);
		addRow(opWrite, addrIrqAck, 16'h0001, 16'h0000, 16'h0000);
		addRow(opWaitIrq, 3'd0, 16'd400, 16'h0000, 16'h0001);
		addRow(opSnapAa, 3'd0, 16'h0000, 16'h0000, 16'h0000);
		addRow(opWrite, addrIrqAck, 16'h0001, 16'h0000, 16'h0000);
		addRow(opWaitIrq, 3'd0, 16'd400, 16'h0000, 16'h0001);
		addRow(opAaStep, 3'd0, 16'd1, 16'h0000, 16'h0000);
		// Frozen once disabled
		addRow(opWrite, addrMode, 16'h0008, 16'h0000, 16'h0000);
		addRow(opSnapAa, 3'd0, 16'h0000, 16'h0000, 16'h0000);
		addRow(opWrite, addrIrqAck, 16'h0001, 16'h0000, 16'h0000);
		addRow(opWaitIrq, 3'd0, 16'd400, 16'h0000, 16'h0001);
		addRow(opAaStep, 3'd0, 16'd0, 16'h0000, 16'h0000);
	endtask

	initial
	begin
		cpuAddr = '0;
		cpuDataIn = '0;
		nLspWe = 1'b1;          // Strobes idle high
		nLspOe = 1'b1;
		nRESET = 1'b0;
		aaSnap = '0;
		buildTable();
		repeat (8) @(posedge clk24M);
		nRESET <= 1'b1;
		checkIdle();
		for (int r = 0; r < rowCount; r++)
		begin
			applyRow(stimTable[r]);
			repeat (rowGap) @(posedge clk24M);
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
logic/lspcBusPkg.sv
logic/lspcVideoPkg.sv
logic/lspcBusPort.sv
logic/lspcVramPort.sv
logic/lspcTimer.sv
logic/lspcRaster.sv
logic/lspcIrqCtrl.sv
logic/lspcTop.sv
tests/lspcTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module lspcTb -f sources.f -o lspcSim

# Simulator exit status is ignored, the log decides
./obj_dir/lspcSim > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
